/* flist.f */
mouse_pkg.sv
ps2_byte_if.sv
ps2_rx.sv
ps2_tx.sv
mouse_packet.sv
mouse_top.sv
tb_ps2_device.sv
tb_mouse.sv

/* mouse_packet.sv */
/* Mouse packet engine
   Polls with Read Data, checks the ack, assembles and decodes the 4-byte packet */
module mouse_packet (
   input  logic                                 clk,
   input  logic                                 reset,
   ps2_byte_if.engine                           byte_in,
   output mouse_pkg::mouse_cmd_e                cmd,
   output logic                                 cmd_valid,
   input  logic                                 cmd_ready,
   output logic signed [8:0]                    x,
   output logic signed [8:0]                    y,
   output logic signed [3:0]                    z,
   output logic                                 button_l,
   output logic                                 button_m,
   output logic                                 button_r,
   output logic                                 packet_valid,
   input  logic                                 packet_ready,
   output logic [mouse_pkg::ERR_COUNT_W-1:0]    error_count
);

   mouse_pkg::packet_state_e state;

   // Packet bytes 1 to 3, byte 4 goes straight to z
   logic [7:0] b1;
   logic [7:0] b2;
   logic [7:0] b3;

   logic fire;
   logic bad;

   //////////////////////////////////////////////////
   // Handshakes

   assign cmd          = mouse_pkg::CMD_READ_DATA;
   assign cmd_valid    = (state == mouse_pkg::PKT_POLL);
   assign packet_valid = (state == mouse_pkg::PKT_PRESENT);

   // Take bytes only while a poll reply is expected
   assign byte_in.ready = state inside {mouse_pkg::PKT_ACK, mouse_pkg::PKT_BYTE1,
                                        mouse_pkg::PKT_BYTE2, mouse_pkg::PKT_BYTE3,
                                        mouse_pkg::PKT_BYTE4};
   assign fire = byte_in.valid & byte_in.ready;

   // Bad frame, wrong ack, or byte 1 without its always-one bit
   always_comb begin
      bad = 1'b0;
      if (fire) begin
         if (!byte_in.frame_ok) begin
            bad = 1'b1;
         end else if (state == mouse_pkg::PKT_ACK) begin
            bad = (byte_in.data != mouse_pkg::ACK_CODE);
         end else if (state == mouse_pkg::PKT_BYTE1) begin
            bad = ~byte_in.data[3];
         end
      end
   end

   //////////////////////////////////////////////////
   // Poll FSM

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= mouse_pkg::PKT_POLL;
      end else if (bad) begin
         // Abandon packet and poll again
         state <= mouse_pkg::PKT_POLL;
      end else begin
         case (state)
            mouse_pkg::PKT_POLL:    if (cmd_ready) state <= mouse_pkg::PKT_ACK;
            mouse_pkg::PKT_ACK:     if (fire) state <= mouse_pkg::PKT_BYTE1;
            mouse_pkg::PKT_BYTE1:   if (fire) state <= mouse_pkg::PKT_BYTE2;
            mouse_pkg::PKT_BYTE2:   if (fire) state <= mouse_pkg::PKT_BYTE3;
            mouse_pkg::PKT_BYTE3:   if (fire) state <= mouse_pkg::PKT_BYTE4;
            mouse_pkg::PKT_BYTE4:   if (fire) state <= mouse_pkg::PKT_PRESENT;
            mouse_pkg::PKT_PRESENT: if (packet_ready) state <= mouse_pkg::PKT_POLL;
            default:                state <= mouse_pkg::PKT_POLL;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Packet capture and decode

   always_ff @(posedge clk) begin
      if (fire && !bad) begin
         case (state)
            mouse_pkg::PKT_BYTE1: b1 <= byte_in.data;
            mouse_pkg::PKT_BYTE2: b2 <= byte_in.data;
            mouse_pkg::PKT_BYTE3: b3 <= byte_in.data;
            mouse_pkg::PKT_BYTE4: begin
               // Byte 1: yovf xovf ysgn xsgn 1 mid right left
               x        <= {b1[4], b2};
               y        <= {b1[5], b3};
               z        <= byte_in.data[3:0];
               button_l <= b1[0];
               button_m <= b1[2];
               button_r <= b1[1];
            end
            default: ;
         endcase
      end
   end

   // Saturating error count
   always_ff @(posedge clk) begin
      if (reset) begin
         error_count <= '0;
      end else if (bad && error_count != '1) begin
         error_count <= error_count + 1'b1;
      end
   end

   // Packet holds under back-pressure
   assert property (@(posedge clk) disable iff (reset)
      packet_valid && !packet_ready |=>
         packet_valid && $stable(x) && $stable(y) && $stable(z) &&
         $stable({button_l, button_m, button_r}))
      else $error("mouse_packet: packet changed while waiting for ready");

endmodule

/* mouse_pkg.sv */
/* Mouse controller package
   State and opcode enums, PS/2 protocol codes and host timing constants */
package mouse_pkg;

   //////////////////////////////////////////////////
   // State encodings

   // Device-to-host frame receiver
   typedef enum logic [2:0] {
      RX_IDLE, RX_DATA, RX_PARITY, RX_STOP, RX_HOLD
   } rx_state_e;

   // Host-to-device sender, request-to-send sequence
   typedef enum logic [2:0] {
      TX_IDLE, TX_INHIBIT, TX_REQUEST, TX_SHIFT, TX_PARITY, TX_STOP, TX_ACK
   } tx_state_e;

   // Poll, acknowledge, four packet bytes, then hand off
   typedef enum logic [2:0] {
      PKT_POLL, PKT_ACK, PKT_BYTE1, PKT_BYTE2, PKT_BYTE3, PKT_BYTE4, PKT_PRESENT
   } packet_state_e;

   // Mouse command opcodes
   typedef enum logic [7:0] {
      CMD_READ_DATA = 8'hEB,
      CMD_RESET     = 8'hFF
   } mouse_cmd_e;

   //////////////////////////////////////////////////
   // Protocol codes and timing

   // Device acknowledge byte
   localparam logic [7:0] ACK_CODE = 8'hFA;

   // PS/2 clock held low before the request, about 100 us at the line rate
   localparam int INHIBIT_CYCLES = 200;
   // Clock and data both low before the clock is let go
   localparam int REQUEST_CYCLES = 20;
   localparam int TX_CNT_W = $clog2(INHIBIT_CYCLES);
   localparam logic [TX_CNT_W-1:0] INHIBIT_LAST = TX_CNT_W'(INHIBIT_CYCLES - 1);
   localparam logic [TX_CNT_W-1:0] REQUEST_LAST = TX_CNT_W'(REQUEST_CYCLES - 1);

   // Saturating error counter
   localparam int ERR_COUNT_W = 8;

endpackage

/* mouse_top.sv */
/* PS/2 mouse controller top level
   Receiver, command sender and packet engine on open-collector PS/2 lines */
module mouse_top (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 ps2_clk_in,
   input  logic                                 ps2_data_in,
   output logic                                 ps2_clk_drive_low,
   output logic                                 ps2_data_drive_low,
   output logic signed [8:0]                    x,
   output logic signed [8:0]                    y,
   output logic signed [3:0]                    z,
   output logic                                 button_l,
   output logic                                 button_m,
   output logic                                 button_r,
   output logic                                 packet_valid,
   input  logic                                 packet_ready,
   output logic [mouse_pkg::ERR_COUNT_W-1:0]    error_count
);

   // Received byte channel
   ps2_byte_if rx_byte ();

   // Command port
   mouse_pkg::mouse_cmd_e cmd;
   logic                  cmd_valid;
   logic                  cmd_ready;
   logic                  tx_busy;

   // Listen only, line drive comes from the sender
   ps2_rx rx_i (
      .clk      (clk),
      .reset    (reset),
      .ps2_clk  (ps2_clk_in),
      .ps2_data (ps2_data_in),
      .byte_out (rx_byte.rx),
      .tx_busy  (tx_busy)
   );

   ps2_tx tx_i (
      .clk            (clk),
      .reset          (reset),
      .ps2_clk        (ps2_clk_in),
      .ps2_data       (ps2_data_in),
      .cmd            (cmd),
      .cmd_valid      (cmd_valid),
      .cmd_ready      (cmd_ready),
      .clk_drive_low  (ps2_clk_drive_low),
      .data_drive_low (ps2_data_drive_low),
      .busy           (tx_busy)
   );

   mouse_packet packet_i (
      .clk          (clk),
      .reset        (reset),
      .byte_in      (rx_byte.engine),
      .cmd          (cmd),
      .cmd_valid    (cmd_valid),
      .cmd_ready    (cmd_ready),
      .x            (x),
      .y            (y),
      .z            (z),
      .button_l     (button_l),
      .button_m     (button_m),
      .button_r     (button_r),
      .packet_valid (packet_valid),
      .packet_ready (packet_ready),
      .error_count  (error_count)
   );

endmodule

/* ps2_byte_if.sv */
/* Received PS/2 byte channel
   One data byte plus frame status, moved under valid/ready */
interface ps2_byte_if;

   // Payload
   logic [7:0] data;
   // Start, parity and stop all good
   logic       frame_ok;

   // Handshake
   logic       valid;
   logic       ready;

   // Receiver side
   modport rx (
      output data,
      output frame_ok,
      output valid,
      input  ready
   );

   // Packet engine side
   modport engine (
      input  data,
      input  frame_ok,
      input  valid,
      output ready
   );

endinterface

/* ps2_rx.sv */
/* PS/2 device-to-host receiver
   Samples 11-bit frames on device clock falls, checks framing, holds the byte */
module ps2_rx (
   input  logic   clk,
   input  logic   reset,
   input  logic   ps2_clk,
   input  logic   ps2_data,
   ps2_byte_if.rx byte_out,
   input  logic   tx_busy
);

   //////////////////////////////////////////////////
   // Line synchronizers and edge detect

   logic [1:0] clk_sync;
   logic [1:0] data_sync;
   logic       clk_prev;
   logic       clk_fall;

   // Lines idle high, so reset to ones
   always_ff @(posedge clk) begin
      if (reset) begin
         clk_sync  <= 2'b11;
         data_sync <= 2'b11;
         clk_prev  <= 1'b1;
      end else begin
         clk_sync  <= {clk_sync[0], ps2_clk};
         data_sync <= {data_sync[0], ps2_data};
         clk_prev  <= clk_sync[1];
      end
   end

   // One pulse per device falling edge
   assign clk_fall = clk_prev & ~clk_sync[1];

   //////////////////////////////////////////////////
   // Frame shifter

   mouse_pkg::rx_state_e state;
   logic [7:0] shift;
   logic [2:0] bit_cnt;
   logic       start_ok;
   logic       parity_bit;
   logic       frame_good;
   logic       handshake;
   logic       held;

   assign handshake = byte_out.valid & byte_out.ready;
   // Previous byte still waiting after this clock
   assign held = byte_out.valid & ~byte_out.ready;

   // Start low, odd parity across data and parity, stop taken live
   assign frame_good = start_ok & (^{shift, parity_bit}) & data_sync[1];

   always_ff @(posedge clk) begin
      if (reset) begin
         state          <= mouse_pkg::RX_IDLE;
         bit_cnt        <= 3'd0;
         byte_out.valid <= 1'b0;
      end else begin
         if (handshake) begin
            byte_out.valid <= 1'b0;
         end
         if (tx_busy) begin
            // Host owns the lines, drop any partial frame
            state <= held ? mouse_pkg::RX_HOLD : mouse_pkg::RX_IDLE;
         end else begin
            case (state)
               mouse_pkg::RX_IDLE, mouse_pkg::RX_HOLD: begin
                  if (clk_fall) begin
                     // Start bit
                     start_ok <= ~data_sync[1];
                     bit_cnt  <= 3'd0;
                     state    <= mouse_pkg::RX_DATA;
                  end else if (state == mouse_pkg::RX_HOLD && handshake) begin
                     state <= mouse_pkg::RX_IDLE;
                  end
               end
               mouse_pkg::RX_DATA: begin
                  if (clk_fall) begin
                     // LSB first
                     shift   <= {data_sync[1], shift[7:1]};
                     bit_cnt <= bit_cnt + 3'd1;
                     if (bit_cnt == 3'd7) begin
                        state <= mouse_pkg::RX_PARITY;
                     end
                  end
               end
               mouse_pkg::RX_PARITY: begin
                  if (clk_fall) begin
                     parity_bit <= data_sync[1];
                     state      <= mouse_pkg::RX_STOP;
                  end
               end
               mouse_pkg::RX_STOP: begin
                  if (clk_fall) begin
                     // Old byte not taken yet, new frame is lost
                     if (!held) begin
                        byte_out.data     <= shift;
                        byte_out.frame_ok <= frame_good;
                        byte_out.valid    <= 1'b1;
                     end
                     state <= mouse_pkg::RX_HOLD;
                  end
               end
               default: state <= mouse_pkg::RX_IDLE;
            endcase
         end
      end
   end

   // Held byte must not move until the engine takes it
   assert property (@(posedge clk) disable iff (reset)
      byte_out.valid && !byte_out.ready |=>
         byte_out.valid && $stable(byte_out.data) && $stable(byte_out.frame_ok))
      else $error("ps2_rx: held byte changed before handshake");

endmodule

/* ps2_tx.sv */
/* PS/2 host-to-device command sender
   Inhibit, request-to-send, shift data and parity, then wait for device ack */
module ps2_tx (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  ps2_clk,
   input  logic                  ps2_data,
   input  mouse_pkg::mouse_cmd_e cmd,
   input  logic                  cmd_valid,
   output logic                  cmd_ready,
   output logic                  clk_drive_low,
   output logic                  data_drive_low,
   output logic                  busy
);

   //////////////////////////////////////////////////
   // Line synchronizers and edge detect

   logic [1:0] clk_sync;
   logic [1:0] data_sync;
   logic       clk_prev;
   logic       clk_fall;

   always_ff @(posedge clk) begin
      if (reset) begin
         clk_sync  <= 2'b11;
         data_sync <= 2'b11;
         clk_prev  <= 1'b1;
      end else begin
         clk_sync  <= {clk_sync[0], ps2_clk};
         data_sync <= {data_sync[0], ps2_data};
         clk_prev  <= clk_sync[1];
      end
   end

   assign clk_fall = clk_prev & ~clk_sync[1];

   //////////////////////////////////////////////////
   // Request-to-send FSM

   mouse_pkg::tx_state_e state;
   logic [mouse_pkg::TX_CNT_W-1:0] cnt;
   logic [2:0] bit_cnt;
   logic [7:0] shift;
   logic       parity_bit;

   assign cmd_ready = (state == mouse_pkg::TX_IDLE);
   assign busy      = (state != mouse_pkg::TX_IDLE);

   // Line pulls are registered so the open-collector drive never glitches
   always_ff @(posedge clk) begin
      if (reset) begin
         state          <= mouse_pkg::TX_IDLE;
         cnt            <= '0;
         bit_cnt        <= 3'd0;
         clk_drive_low  <= 1'b0;
         data_drive_low <= 1'b0;
      end else begin
         case (state)
            mouse_pkg::TX_IDLE: begin
               if (cmd_valid) begin
                  shift         <= cmd;
                  // Odd parity
                  parity_bit    <= ~^cmd;
                  cnt           <= '0;
                  clk_drive_low <= 1'b1;
                  state         <= mouse_pkg::TX_INHIBIT;
               end
            end
            mouse_pkg::TX_INHIBIT: begin
               cnt <= cnt + 1'b1;
               if (cnt == mouse_pkg::INHIBIT_LAST) begin
                  // Data low doubles as the start bit
                  cnt            <= '0;
                  data_drive_low <= 1'b1;
                  state          <= mouse_pkg::TX_REQUEST;
               end
            end
            mouse_pkg::TX_REQUEST: begin
               cnt <= cnt + 1'b1;
               if (cnt == mouse_pkg::REQUEST_LAST) begin
                  // Let go of the clock, device starts clocking
                  clk_drive_low <= 1'b0;
                  bit_cnt       <= 3'd0;
                  state         <= mouse_pkg::TX_SHIFT;
               end
            end
            mouse_pkg::TX_SHIFT: begin
               if (clk_fall) begin
                  // New bit while clock low, device samples on the rise
                  data_drive_low <= ~shift[0];
                  shift          <= {1'b0, shift[7:1]};
                  bit_cnt        <= bit_cnt + 3'd1;
                  if (bit_cnt == 3'd7) begin
                     state <= mouse_pkg::TX_PARITY;
                  end
               end
            end
            mouse_pkg::TX_PARITY: begin
               if (clk_fall) begin
                  data_drive_low <= ~parity_bit;
                  state          <= mouse_pkg::TX_STOP;
               end
            end
            mouse_pkg::TX_STOP: begin
               if (clk_fall) begin
                  // Stop bit is the released line
                  data_drive_low <= 1'b0;
                  state          <= mouse_pkg::TX_ACK;
               end
            end
            mouse_pkg::TX_ACK: begin
               // Device pulls data low for one clock
               if (clk_fall && !data_sync[1]) begin
                  state <= mouse_pkg::TX_IDLE;
               end
            end
            default: state <= mouse_pkg::TX_IDLE;
         endcase
      end
   end

   // Host clock pull only during inhibit and request
   assert property (@(posedge clk) disable iff (reset)
      clk_drive_low |-> state inside {mouse_pkg::TX_INHIBIT, mouse_pkg::TX_REQUEST})
      else $error("ps2_tx: clock pulled low outside request sequence");

endmodule

/* tb_mouse.sv */
/* PS/2 mouse controller testbench
   Random packets and faults through a device model, checked against a reference queue */
module tb_mouse;

   localparam int NUM_POLLS = 40;
   localparam int PERIOD = 40;
   // Packets x frames x bits x clocks per bit, doubled
   localparam int WATCHDOG_CYCLES = 2 * NUM_POLLS * 5 * 11 * 20;

   logic                              clk;
   logic                              reset;
   logic                              ps2_clk;
   logic                              ps2_data;
   logic                              clk_drive_low;
   logic                              data_drive_low;
   logic signed [8:0]                 x;
   logic signed [8:0]                 y;
   logic signed [3:0]                 z;
   logic                              button_l;
   logic                              button_m;
   logic                              button_r;
   logic                              packet_valid;
   logic                              packet_ready;
   logic [mouse_pkg::ERR_COUNT_W-1:0] error_count;
   logic                              out_of_replies;
   int                                device_faults;

   logic [15:0] lfsr;
   // Expected {x, y, z, left, middle, right}
   logic [24:0] expected_q [$];
   int          expected_errors;
   int          expected_packets;
   int          received;
   int          errors;

   mouse_top dut_i (
      .clk                (clk),
      .reset              (reset),
      .ps2_clk_in         (ps2_clk),
      .ps2_data_in        (ps2_data),
      .ps2_clk_drive_low  (clk_drive_low),
      .ps2_data_drive_low (data_drive_low),
      .x                  (x),
      .y                  (y),
      .z                  (z),
      .button_l           (button_l),
      .button_m           (button_m),
      .button_r           (button_r),
      .packet_valid       (packet_valid),
      .packet_ready       (packet_ready),
      .error_count        (error_count)
   );

   tb_ps2_device dev_i (
      .clk            (clk),
      .host_clk_low   (clk_drive_low),
      .host_data_low  (data_drive_low),
      .ps2_clk        (ps2_clk),
      .ps2_data       (ps2_data),
      .out_of_replies (out_of_replies),
      .fault_count    (device_faults)
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Random source and checking

   // x^16 + x^14 + x^13 + x^11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [15:0] take_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[14:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, expected);
         errors++;
      end
   endtask

   //////////////////////////////////////////////////
   // Reply generation and reference model

   task automatic build_replies();
      logic [8:0] mx;
      logic [8:0] my;
      logic [3:0] mz;
      logic [2:0] btn;
      logic [2:0] fault;
      logic [7:0] ack;
      logic [7:0] b1;
      logic [7:0] b4;
      int         bad_frame;
      for (int n = 0; n < NUM_POLLS; n++) begin
         mx    = 9'(take_bits(9));
         my    = 9'(take_bits(9));
         mz    = 4'(take_bits(4));
         btn   = 3'(take_bits(3));
         fault = 3'(take_bits(3));
         // First two packets sit at the range ends
         if (n < 2) begin
            mx    = (n == 0) ? 9'h100 : 9'h0FF;
            my    = (n == 0) ? 9'h0FF : 9'h100;
            mz    = (n == 0) ? 4'h8 : 4'h7;
            fault = 3'd7;
         end
         ack       = mouse_pkg::ACK_CODE;
         // Overflow bits random, sign bits from movement, bit 3 always set
         b1        = {2'(take_bits(2)), my[8], mx[8], 1'b1, btn[1], btn[0], btn[2]};
         b4        = {4'(take_bits(4)), mz};
         bad_frame = -1;
         case (fault)
            3'd0: bad_frame = take_bits(3) % 5;
            3'd1: begin
               ack = 8'(take_bits(8));
               if (ack == mouse_pkg::ACK_CODE) begin
                  ack = 8'hFE;
               end
            end
            3'd2: b1[3] = 1'b0;
            default: ;
         endcase
         if (fault <= 3'd2) begin
            if (expected_errors < 255) expected_errors++;
         end else begin
            expected_q.push_back({mx, my, mz, btn});
         end
         dev_i.queue_reply({ack, b1, mx[7:0], my[7:0], b4}, bad_frame);
      end
      expected_packets = expected_q.size();
   endtask

   // Random ready stretches, packet order and hold checks, sampled after the edge
   task automatic watch_packets();
      logic [24:0] now;
      logic [24:0] held;
      logic        holding;
      logic        ready_level;
      logic [7:0]  last_err;
      int          stretch;
      holding     = 1'b0;
      ready_level = 1'b1;
      last_err    = '0;
      stretch     = 0;
      forever begin
         @(posedge clk);
         #2;
         now = {x, y, z, button_l, button_m, button_r};
         if (holding) begin
            check_value("packet_valid", packet_valid, 1);
            check_value("held packet", now, held);
         end
         // Errors count up one at a time
         if (error_count != last_err) begin
            check_value("error_count", error_count, 8'(last_err + 1));
         end
         last_err = error_count;
         if (stretch == 0) begin
            ready_level = 1'(take_bits(1));
            stretch     = int'(take_bits(5));
         end else begin
            stretch--;
         end
         packet_ready = ready_level;
         if (packet_valid && ready_level) begin
            if (expected_q.size() == 0) begin
               $display("extra packet at %0t with no packet left to expect", $time);
               errors++;
            end else begin
               check_value("packet", now, expected_q.pop_front());
            end
            received++;
         end
         holding = packet_valid && !ready_level;
         held    = now;
      end
   endtask

   //////////////////////////////////////////////////
   // Main sequence

   initial begin
      reset           = 1'b1;
      packet_ready    = 1'b0;
      lfsr            = 16'd22993;
      expected_errors = 0;
      received        = 0;
      errors          = 0;
      build_replies();
      repeat (8) @(posedge clk);
      #2;
      // Reset state
      check_value("packet_valid", packet_valid, 0);
      check_value("ps2_clk_drive_low", clk_drive_low, 0);
      check_value("ps2_data_drive_low", data_drive_low, 0);
      check_value("error_count", error_count, 0);
      reset = 1'b0;
      fork
         watch_packets();
      join_none
      // Device runs dry once every reply is used
      wait (out_of_replies);
      repeat (20) @(posedge clk);
      check_value("error_count", error_count, expected_errors);
      check_value("packets received", received, expected_packets);
      check_value("packets left", expected_q.size(), 0);
      errors += device_faults;
      $display("errors: %0d (device faults %0d)", errors, device_faults);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: the test did not finish within %0d clocks", WATCHDOG_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

/* tb_ps2_device.sv */
/* Behavioral PS/2 wheel mouse
   Checks host commands, then answers with an acknowledge byte and a queued packet */
module tb_ps2_device (
   input  logic clk,
   input  logic host_clk_low,
   input  logic host_data_low,
   output logic ps2_clk,
   output logic ps2_data,
   output logic out_of_replies,
   output int   fault_count
);

   logic       dev_clk_low;
   logic       dev_data_low;
   // Five frames per reply, ack first
   logic [7:0] byte_q [$];
   logic       flip_q [$];

   // Open-collector lines, low when either side pulls
   assign ps2_clk  = ~(host_clk_low | dev_clk_low);
   assign ps2_data = ~(host_data_low | dev_data_low);

   // Frames packed ack first, bad_frame picks one parity bit to flip
   task automatic queue_reply(input logic [39:0] frames, input int bad_frame);
      for (int f = 0; f < 5; f++) begin
         byte_q.push_back(frames[39 - 8 * f -: 8]);
         flip_q.push_back(f == bad_frame);
      end
   endtask

   // Advance n system clocks, lines move just after the edge
   task automatic step(input int n);
      repeat (n) @(posedge clk);
      #2;
   endtask

   // One PS/2 clock period of 20 system clocks, data read on the rise
   task automatic clock_pulse(output logic sampled);
      step(5);
      dev_clk_low = 1'b1;
      step(10);
      dev_clk_low = 1'b0;
      sampled = ps2_data;
      step(5);
   endtask

   task automatic read_command();
      logic [9:0] bits;
      logic       b;
      // 8 data bits, parity, stop
      for (int i = 0; i < 10; i++) begin
         clock_pulse(b);
         bits[i] = b;
      end
      // Ack bit, data held low across one pulse
      dev_data_low = 1'b1;
      clock_pulse(b);
      dev_data_low = 1'b0;
      if (bits[7:0] != mouse_pkg::CMD_READ_DATA) begin
         $display("device: at %0t the host sent command %0h instead of read data",
                  $time, bits[7:0]);
         fault_count++;
      end
      if (^bits[8:0] != 1'b1) begin
         $display("device: at %0t the host command has even parity", $time);
         fault_count++;
      end
      if (!bits[9]) begin
         $display("device: at %0t the host command has no stop bit", $time);
         fault_count++;
      end
   endtask

   task automatic send_frame(input logic [7:0] data, input logic flip);
      logic [10:0] bits;
      logic        unused;
      // Stop, odd parity, data LSB first, start
      bits = {1'b1, (~^data) ^ flip, data, 1'b0};
      for (int i = 0; i < 11; i++) begin
         dev_data_low = ~bits[i];
         clock_pulse(unused);
      end
      dev_data_low = 1'b0;
   endtask

   task automatic send_reply();
      logic [7:0] data;
      logic       flip;
      logic       dropped;
      dropped = 1'b0;
      step(20);
      for (int f = 0; f < 5; f++) begin
         data = byte_q.pop_front();
         flip = flip_q.pop_front();
         // Host inhibit cancels the rest of the reply
         if (host_clk_low) begin
            dropped = 1'b1;
         end
         if (!dropped) begin
            send_frame(data, flip);
            step(20);
         end
      end
   endtask

   initial begin
      dev_clk_low    = 1'b0;
      dev_data_low   = 1'b0;
      out_of_replies = 1'b0;
      fault_count    = 0;
      forever begin
         // Request to send: inhibit, then clock released with data low
         step(1);
         while (!host_clk_low) step(1);
         while (host_clk_low || !host_data_low) step(1);
         read_command();
         if (byte_q.size() < 5) begin
            out_of_replies = 1'b1;
         end else begin
            send_reply();
         end
      end
   end

endmodule
